// File: hw/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// cache geometry
`define DCACHE_WAYS       4
`define DCACHE_SETS       16
`define DCACHE_LINE_BITS  256
`define DCACHE_WORD_BITS  32
`define DCACHE_ADDR_BITS  32

// derived address split
`define DCACHE_OFFSET_BITS    5
`define DCACHE_SET_BITS       4
`define DCACHE_TAG_BITS       23
`define DCACHE_WORD_IDX_BITS  (`DCACHE_OFFSET_BITS - 2)
`define DCACHE_LINE_BYTES     (`DCACHE_LINE_BITS / 8)

`endif

// File: hw/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    typedef logic [1:0] way_t;

    // field view of an address, msb first
    typedef struct packed {
        logic [`DCACHE_TAG_BITS-1:0]      tag;
        logic [`DCACHE_SET_BITS-1:0]      set;
        logic [`DCACHE_WORD_IDX_BITS-1:0] word;
        logic [1:0]                       byte_idx;
    } addr_fields_t;

    typedef union packed {
        logic [`DCACHE_ADDR_BITS-1:0] raw;
        addr_fields_t                 f;
    } addr_u;

    // request held between accept and resp
    typedef struct packed {
        logic                         valid;
        addr_u                        addr;
        logic [3:0]                   rmask;
        logic [3:0]                   wmask;
        logic [`DCACHE_WORD_BITS-1:0] wdata;
    } req_t;

endpackage

// File: hw/dcache_array_if.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

interface dcache_array_if;

    logic [`DCACHE_SET_BITS-1:0]   set;
    dcache_pkg::way_t              wr_way;
    logic                          wr_tag;
    logic                          wr_data;
    logic [`DCACHE_LINE_BYTES-1:0] wr_byte_en;
    logic [`DCACHE_TAG_BITS-1:0]   tag_in;
    logic [`DCACHE_LINE_BITS-1:0]  data_in;
    logic                          wr_valid;
    logic                          valid_in;
    logic                          wr_dirty;
    logic                          dirty_in;

    // one per way, registered from the previous cycle's set
    logic [`DCACHE_TAG_BITS-1:0]   tag_out   [`DCACHE_WAYS];
    logic [`DCACHE_LINE_BITS-1:0]  data_out  [`DCACHE_WAYS];
    logic                          valid_out [`DCACHE_WAYS];
    logic                          dirty_out [`DCACHE_WAYS];

    modport ctrl (
        output set, wr_way, wr_tag, wr_data, wr_byte_en, tag_in, data_in,
        output wr_valid, valid_in, wr_dirty, dirty_in,
        input  tag_out, data_out, valid_out, dirty_out
    );

    modport ways (
        input  set, wr_way, wr_tag, wr_data, wr_byte_en, tag_in, data_in,
        input  wr_valid, valid_in, wr_dirty, dirty_in,
        output tag_out, data_out, valid_out, dirty_out
    );

endinterface

// File: hw/dcache_ways.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ways (
    input logic          clk,
    input logic          rst,
    dcache_array_if.ways arr
);

    logic [`DCACHE_TAG_BITS-1:0]  tag_mem   [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_LINE_BITS-1:0] data_mem  [`DCACHE_WAYS][`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0]      valid_mem [`DCACHE_WAYS];
    logic [`DCACHE_SETS-1:0]      dirty_mem [`DCACHE_WAYS];

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        logic sel;

        assign sel = (arr.wr_way == dcache_pkg::way_t'(w));

        // tag and line payload
        always_ff @(posedge clk) begin
            if (sel && arr.wr_tag) begin
                tag_mem[w][arr.set] <= arr.tag_in;
            end
            if (sel && arr.wr_data) begin
                for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
                    if (arr.wr_byte_en[b]) begin
                        data_mem[w][arr.set][8*b +: 8] <= arr.data_in[8*b +: 8];
                    end
                end
            end
            arr.tag_out[w]  <= tag_mem[w][arr.set];   // old value on same-edge write
            arr.data_out[w] <= data_mem[w][arr.set];
        end

        // state bits
        always_ff @(posedge clk) begin
            if (rst) begin
                valid_mem[w]     <= '0;
                dirty_mem[w]     <= '0;
                arr.valid_out[w] <= 1'b0;
                arr.dirty_out[w] <= 1'b0;
            end else begin
                if (sel && arr.wr_valid) begin
                    valid_mem[w][arr.set] <= arr.valid_in;
                end
                if (sel && arr.wr_dirty) begin
                    dirty_mem[w][arr.set] <= arr.dirty_in;
                end
                arr.valid_out[w] <= valid_mem[w][arr.set];
                arr.dirty_out[w] <= dirty_mem[w][arr.set];
            end
        end
    end

    // the controller must never strobe a write with a floating way select
    way_known: assert property (
        @(posedge clk) disable iff (rst)
        (arr.wr_tag || arr.wr_data || arr.wr_valid || arr.wr_dirty)
            |-> !$isunknown(arr.wr_way)
    );

endmodule

// File: hw/dcache_plru.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_plru (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`DCACHE_SET_BITS-1:0] set,
    input  logic                        touch,
    input  dcache_pkg::way_t            touch_way,
    output dcache_pkg::way_t            victim
);

    //        [0]
    //       /   \
    //     [1]   [2]
    //    /  \   /  \
    //   w0  w1 w2  w3
    // each bit points toward the side to evict next
    logic [2:0] tree [`DCACHE_SETS];
    logic [2:0] cur;
    logic [2:0] upd;

    assign cur    = tree[set];
    assign victim = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};

    always_comb begin
        upd    = cur;
        upd[0] = ~touch_way[1];   // root away from touched half
        if (touch_way[1]) begin
            upd[2] = ~touch_way[0];
        end else begin
            upd[1] = ~touch_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[set] <= upd;
        end
    end

    // controller holds off while in reset
    no_touch_in_rst: assert property (
        @(posedge clk) rst |-> !touch
    );

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`DCACHE_ADDR_BITS-1:0]  addr,
    input  logic [3:0]                    rmask,
    input  logic [3:0]                    wmask,
    input  logic [`DCACHE_WORD_BITS-1:0]  wdata,
    output logic [`DCACHE_WORD_BITS-1:0]  rdata,
    output logic                          resp,
    output logic                          stall,
    output logic [`DCACHE_ADDR_BITS-1:0]  dfp_addr,
    output logic                          dfp_read,
    output logic                          dfp_write,
    output logic [`DCACHE_LINE_BITS-1:0]  dfp_wdata,
    input  logic [`DCACHE_LINE_BITS-1:0]  dfp_rdata,
    input  logic                          dfp_resp,
    dcache_array_if.ctrl                  arr,
    output logic [`DCACHE_SET_BITS-1:0]   plru_set,
    output logic                          plru_touch,
    output dcache_pkg::way_t              plru_touch_way,
    input  dcache_pkg::way_t              victim
);

    typedef enum logic [1:0] {LOOKUP, WRITE_BACK, FILL, RELOOK} state_t;

    state_t state, state_next;

    dcache_pkg::req_t  req;
    dcache_pkg::addr_u in_addr;
    dcache_pkg::addr_u wb_addr;
    dcache_pkg::way_t  hit_way;

    logic [`DCACHE_WAYS-1:0] hit_vec;
    logic hit;
    logic miss;
    logic is_store;
    logic accept;
    logic wb_done;
    logic fill_done;

    assign in_addr.raw = addr;

    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_vec[w] = arr.valid_out[w] && (arr.tag_out[w] == req.addr.f.tag);
            if (hit_vec[w]) begin
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign is_store  = |req.wmask;
    assign hit       = req.valid && (state == LOOKUP) && (|hit_vec);
    assign miss      = req.valid && (state == LOOKUP) && !(|hit_vec);
    assign wb_done   = (state == WRITE_BACK) && dfp_resp;
    assign fill_done = (state == FILL) && dfp_resp;

    // a read hit frees the slot right away, a store hit holds it one more cycle
    assign resp   = hit;
    assign stall  = req.valid && !(hit && !is_store);
    assign accept = !stall && (|rmask || |wmask);
    assign rdata  = arr.data_out[hit_way][`DCACHE_WORD_BITS*req.addr.f.word +: `DCACHE_WORD_BITS];

    always_ff @(posedge clk) begin
        if (accept) begin
            req.addr  <= in_addr;
            req.rmask <= rmask;
            req.wmask <= wmask;
            req.wdata <= wdata;
        end
        if (rst) begin
            req.valid <= 1'b0;
        end else if (!stall) begin
            req.valid <= accept;
        end else if (resp) begin
            req.valid <= 1'b0;   // store hit done
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOOKUP: begin
                if (miss) begin
                    state_next = arr.dirty_out[victim] ? WRITE_BACK : FILL;
                end
            end
            WRITE_BACK: if (dfp_resp) state_next = FILL;
            FILL:       if (dfp_resp) state_next = RELOOK;
            RELOOK:     state_next = LOOKUP;   // arrays re-read the new line
            default:    state_next = LOOKUP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LOOKUP;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        arr.set        = accept ? in_addr.f.set : req.addr.f.set;
        arr.wr_way     = hit_way;
        arr.wr_tag     = 1'b0;
        arr.wr_data    = 1'b0;
        arr.wr_byte_en = '0;
        arr.tag_in     = req.addr.f.tag;
        arr.data_in    = {(`DCACHE_LINE_BITS / `DCACHE_WORD_BITS){req.wdata}};
        arr.wr_valid   = 1'b0;
        arr.valid_in   = 1'b1;
        arr.wr_dirty   = 1'b0;
        arr.dirty_in   = 1'b1;
        if (hit && is_store) begin
            arr.wr_data = 1'b1;
            arr.wr_byte_en[4*req.addr.f.word +: 4] = req.wmask;
            arr.wr_dirty = 1'b1;
        end
        if (wb_done) begin
            arr.wr_way   = victim;
            arr.wr_dirty = 1'b1;
            arr.dirty_in = 1'b0;
        end
        if (fill_done) begin
            arr.wr_way     = victim;
            arr.wr_tag     = 1'b1;
            arr.wr_data    = 1'b1;
            arr.wr_byte_en = '1;
            arr.data_in    = dfp_rdata;
            arr.wr_valid   = 1'b1;
            arr.wr_dirty   = 1'b1;
            arr.dirty_in   = 1'b0;
        end
    end

    // victim line goes back to its own address
    always_comb begin
        wb_addr.raw   = '0;
        wb_addr.f.tag = arr.tag_out[victim];
        wb_addr.f.set = req.addr.f.set;
    end

    assign dfp_read  = (state == FILL);
    assign dfp_write = (state == WRITE_BACK);
    assign dfp_wdata = arr.data_out[victim];
    assign dfp_addr  = dfp_write ? wb_addr.raw
                     : {req.addr.raw[`DCACHE_ADDR_BITS-1:`DCACHE_OFFSET_BITS],
                        {(`DCACHE_OFFSET_BITS){1'b0}}};

    assign plru_set       = req.addr.f.set;
    assign plru_touch     = hit || fill_done;
    assign plru_touch_way = fill_done ? victim : hit_way;

    one_hit: assert property (
        @(posedge clk) disable iff (rst)
        (req.valid && state == LOOKUP) |-> $onehot0(hit_vec)
    );

    no_rd_wr: assert property (
        @(posedge clk) disable iff (rst) !(dfp_read && dfp_write)
    );

    req_held: assert property (
        @(posedge clk) disable iff (rst) (stall && !resp) |=> $stable(req)
    );

endmodule

// File: hw/dcache.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [`DCACHE_ADDR_BITS-1:0]  addr,
    input  logic [3:0]                    rmask,
    input  logic [3:0]                    wmask,
    input  logic [`DCACHE_WORD_BITS-1:0]  wdata,
    output logic [`DCACHE_WORD_BITS-1:0]  rdata,
    output logic                          resp,
    output logic [`DCACHE_ADDR_BITS-1:0]  dfp_addr,
    output logic                          dfp_read,
    output logic                          dfp_write,
    output logic [`DCACHE_LINE_BITS-1:0]  dfp_wdata,
    input  logic [`DCACHE_LINE_BITS-1:0]  dfp_rdata,
    input  logic                          dfp_resp,
    output logic                          stall
);

    dcache_array_if arr ();

    logic [`DCACHE_SET_BITS-1:0] plru_set;
    logic                        plru_touch;
    dcache_pkg::way_t            plru_touch_way;
    dcache_pkg::way_t            victim;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .addr           (addr),
        .rmask          (rmask),
        .wmask          (wmask),
        .wdata          (wdata),
        .rdata          (rdata),
        .resp           (resp),
        .stall          (stall),
        .dfp_addr       (dfp_addr),
        .dfp_read       (dfp_read),
        .dfp_write      (dfp_write),
        .dfp_wdata      (dfp_wdata),
        .dfp_rdata      (dfp_rdata),
        .dfp_resp       (dfp_resp),
        .arr            (arr.ctrl),
        .plru_set       (plru_set),
        .plru_touch     (plru_touch),
        .plru_touch_way (plru_touch_way),
        .victim         (victim)
    );

    dcache_ways u_ways (
        .clk (clk),
        .rst (rst),
        .arr (arr.ways)
    );

    dcache_plru u_plru (
        .clk       (clk),
        .rst       (rst),
        .set       (plru_set),
        .touch     (plru_touch),
        .touch_way (plru_touch_way),
        .victim    (victim)
    );

endmodule

// File: sim/dcache_mem_model.sv
`timescale 1ns/1ps

module dcache_mem_model #(
    parameter logic [31:0] pattern_base = 32'h0
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [31:0]  dfp_addr,
    input  logic         dfp_read,
    input  logic         dfp_write,
    input  logic [255:0] dfp_wdata,
    output logic [255:0] dfp_rdata,
    output logic         dfp_resp
);

    logic [255:0] lines [logic [26:0]];   // only lines written back
    logic [31:0]  wb_addr_log [16];
    logic [255:0] wb_data_log [16];
    int           wb_count   = 0;
    int           fill_count = 0;
    logic [31:0]  rng        = 32'h64bc6750;
    logic         busy       = 1'b0;
    int           wait_left  = 0;
    logic         resp_q     = 1'b0;
    logic [255:0] rdata_q    = '0;

    assign dfp_resp  = resp_q;
    assign dfp_rdata = rdata_q;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // untouched lines read as word address plus pattern_base
    function automatic logic [255:0] line_at(input logic [26:0] idx);
        logic [255:0] line;
        for (int i = 0; i < 8; i++) begin
            line[32*i +: 32] = {2'b00, idx, 3'(i)} + pattern_base;
        end
        if (lines.exists(idx)) begin
            line = lines[idx];
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            busy = 1'b0;
            resp_q <= 1'b0;
        end else if (busy) begin
            if (wait_left == 0) begin
                busy = 1'b0;
                resp_q <= 1'b1;
                if (dfp_write) begin
                    lines[dfp_addr[31:5]] = dfp_wdata;
                    if (wb_count < 16) begin
                        wb_addr_log[wb_count] = dfp_addr;
                        wb_data_log[wb_count] = dfp_wdata;
                    end
                    wb_count++;
                end else begin
                    rdata_q <= line_at(dfp_addr[31:5]);
                    fill_count++;
                end
            end else begin
                wait_left--;
            end
        end else begin
            resp_q <= 1'b0;
            if (!resp_q && (dfp_read || dfp_write)) begin
                rng = xorshift(rng);
                wait_left = int'(rng % 32'd6);   // answer 1 to 6 edges later
                busy = 1'b1;
            end
        end
    end

endmodule

// File: sim/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam logic [31:0] pattern_base = 32'h3c00_0000;
    localparam int          wait_limit   = 60;
    localparam logic [31:0] st_word      = 32'haabb_ccdd;

    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic        must_hit;   // 1 cycle, no memory traffic
        logic [3:0]  wbs;        // write-backs seen so far
    } row_t;

    logic         clk = 1'b0;
    logic         rst;
    logic [31:0]  addr;
    logic [3:0]   rmask;
    logic [3:0]   wmask;
    logic [31:0]  wdata;
    logic [31:0]  rdata;
    logic         resp;
    logic         stall;
    logic [31:0]  dfp_addr;
    logic         dfp_read;
    logic         dfp_write;
    logic [255:0] dfp_wdata;
    logic [255:0] dfp_rdata;
    logic         dfp_resp;

    row_t  rows  [$];
    string names [$];
    int    value_errors = 0;
    int    timeouts     = 0;

    always #50 clk = ~clk;

    dcache dut (.*);

    dcache_mem_model #(.pattern_base(pattern_base)) mem (.*);

    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return (a >> 2) + pattern_base;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) w[8*b +: 8] = new_word[8*b +: 8];
        end
        return w;
    endfunction

    task automatic add_row(input string name, input logic [31:0] a, input logic [3:0] rm,
                           input logic [3:0] wm, input logic [31:0] wd,
                           input logic [31:0] exp_word, input logic hit_only,
                           input logic [3:0] wbs);
        names.push_back(name);
        rows.push_back(row_t'{a, rm, wm, wd, exp_word, hit_only, wbs});
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_idle(input string name);
        check_value(name, 32'd0, {28'd0, resp, dfp_read, dfp_write, stall});
    endtask

    // request stays on the inputs until a cycle with stall low
    task automatic wait_accept(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (stall && cycles < wait_limit);
        if (stall) begin
            $display("timeout: %s was never accepted", name);
            timeouts++;
        end
        @(posedge clk);   // accepting edge
    endtask

    task automatic run_row(input int i);
        row_t r;
        int   cycles;
        int   fills;
        r = rows[i];
        fills = mem.fill_count;
        @(posedge clk);
        addr  <= r.addr;
        rmask <= r.rmask;
        wmask <= r.wmask;
        wdata <= r.wdata;
        wait_accept(names[i]);
        rmask <= 4'h0;
        wmask <= 4'h0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!resp && cycles < wait_limit);
        if (!resp) begin
            $display("timeout: %s got no response", names[i]);
            timeouts++;
        end else begin
            if (r.rmask != 4'h0) check_value(names[i], r.expected, rdata);
            if (r.must_hit) begin
                check_value({names[i], " latency"}, 32'd1, cycles);
                check_value({names[i], " fills"}, fills, mem.fill_count);
            end else begin
                assert (mem.fill_count > fills) else begin
                    $display("%s should miss but no line fill was seen", names[i]);
                    value_errors++;
                end
            end
            check_value({names[i], " write-backs"}, 32'(r.wbs), mem.wb_count);
        end
    endtask

    // second read lands in the response cycle of the first
    task automatic run_back_to_back(input logic [31:0] a0, input logic [31:0] a1);
        @(posedge clk);
        addr  <= a0;
        rmask <= 4'hf;
        wait_accept("b2b_first");
        addr <= a1;
        @(negedge clk);
        check_value("b2b_first resp", 32'd1, 32'(resp));
        check_value("b2b_first", pattern_word(a0), rdata);
        check_value("b2b stall", 32'd0, 32'(stall));
        @(posedge clk);
        rmask <= 4'h0;
        @(negedge clk);
        check_value("b2b_second resp", 32'd1, 32'(resp));
        check_value("b2b_second", pattern_word(a1), rdata);
    endtask

    initial begin
        rst   = 1'b1;
        addr  = '0;
        rmask = '0;
        wmask = '0;
        wdata = '0;

        add_row("rd_miss", 32'h0000_1040, 4'hf, 4'h0, 32'h0, pattern_word(32'h1040), 1'b0, 4'd0);
        add_row("rd_hit", 32'h0000_1044, 4'hf, 4'h0, 32'h0, pattern_word(32'h1044), 1'b1, 4'd0);
        add_row("st_mask", 32'h0000_1048, 4'h0, 4'h5, st_word, 32'h0, 1'b1, 4'd0);
        add_row("rd_merged", 32'h0000_1048, 4'hf, 4'h0, 32'h0,
                merge_bytes(pattern_word(32'h1048), st_word, 4'h5), 1'b1, 4'd0);
        // set 5 fills ways 0, 2, 1, 3 and then points back at way 0
        add_row("st_set5_a", 32'h0000_20a0, 4'h0, 4'hf, 32'h1111_0000, 32'h0, 1'b0, 4'd0);
        add_row("st_set5_b", 32'h0000_22a0, 4'h0, 4'hf, 32'h2222_1111, 32'h0, 1'b0, 4'd0);
        add_row("st_set5_c", 32'h0000_24a0, 4'h0, 4'hf, 32'h3333_2222, 32'h0, 1'b0, 4'd0);
        add_row("st_set5_d", 32'h0000_26a0, 4'h0, 4'hf, 32'h4444_3333, 32'h0, 1'b0, 4'd0);
        add_row("rd_evict", 32'h0000_28a0, 4'hf, 4'h0, 32'h0, pattern_word(32'h28a0), 1'b0, 4'd1);
        add_row("rd_refetch", 32'h0000_20a0, 4'hf, 4'h0, 32'h0, 32'h1111_0000, 1'b0, 4'd2);

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_idle("idle in reset");
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle("idle after reset");

        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        check_value("first write-back address", 32'h0000_20a0, mem.wb_addr_log[0]);
        check_value("first write-back word", 32'h1111_0000, mem.wb_data_log[0][31:0]);

        run_back_to_back(32'h0000_104c, 32'h0000_28a4);

        $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: dcache.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_array_if.sv
hw/dcache_ways.sv
hw/dcache_plru.sv
hw/dcache_ctrl.sv
hw/dcache.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= dcache.f
TB_TOP    ?= dcache_tb
RTL_TOP   ?= dcache
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
SOURCES   := $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	-$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "Result: PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
